// File: hw/alloc_defs.svh
// heap allocator parameters: address width, header size and split threshold
`ifndef ALLOC_DEFS_SVH
`define ALLOC_DEFS_SVH

// addresses and block sizes share one width
`define ADDR_W 32

// size field followed by next field
`define HDR_BYTES 8

// smallest leftover that becomes a free block of its own
`define MIN_SPLIT 16

`endif

// File: hw/heap_pkg.sv
// heap types: byte addresses, block sizes and the fit strategy
`include "alloc_defs.svh"

package heap_pkg;

  typedef logic [`ADDR_W-1:0] addr_t;      // byte address
  typedef logic [`ADDR_W-1:0] blk_size_t;  // payload bytes, header not counted

  // chosen per request
  typedef enum logic {
    FIRST_FIT = 1'b0,
    BEST_FIT  = 1'b1
  } alloc_strategy_e;

endpackage

// File: hw/mem_pkg.sv
// memory port types: operations on block headers
package mem_pkg;

  typedef enum logic [1:0] {
    MEM_LOAD         = 2'd0,  // returns size and next
    MEM_WRITE_HEADER = 2'd1,  // size and next
    MEM_WRITE_NEXT   = 2'd2   // next only
  } mem_op_e;

endpackage

// File: hw/mem_cmd_if.sv
// memory command channel to the sequencer and the walk result bundle
interface mem_cmd_if
  import heap_pkg::*;
  import mem_pkg::*;
();
  logic      cmd_valid;  // held with its fields until cmd_done
  mem_op_e   cmd_op;
  addr_t     cmd_addr;
  blk_size_t cmd_size;
  addr_t     cmd_next;
  logic      cmd_done;   // single-cycle pulse
  blk_size_t rsp_size;
  addr_t     rsp_next;

  modport client (output cmd_valid, cmd_op, cmd_addr, cmd_size, cmd_next,
                  input cmd_done, rsp_size, rsp_next);
  modport server (input cmd_valid, cmd_op, cmd_addr, cmd_size, cmd_next,
                  output cmd_done, rsp_size, rsp_next);
endinterface

// stable from walk_done until the next walk start
interface walk_result_if
  import heap_pkg::*;
();
  logic      found;
  addr_t     prev_addr;  // header whose next field gets relinked
  addr_t     blk_addr;
  blk_size_t blk_size;
  addr_t     blk_next;

  modport producer (output found, prev_addr, blk_addr, blk_size, blk_next);
  modport consumer (input found, prev_addr, blk_addr, blk_size, blk_next);
endinterface

// File: hw/mem_sequencer.sv
// memory sequencer: serves walker and updater commands on the external port
module mem_sequencer
  import heap_pkg::*;
  import mem_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  mem_cmd_if.server walk_mem,
  mem_cmd_if.server upd_mem,
  output logic      mem_req_valid_o,
  input  logic      mem_req_ready_i,
  output mem_op_e   mem_req_op_o,
  output addr_t     mem_req_addr_o,
  output blk_size_t mem_req_size_o,
  output addr_t     mem_req_next_o,
  input  logic      mem_rsp_valid_i,
  input  blk_size_t mem_rsp_size_i,
  input  addr_t     mem_rsp_next_i
);

  typedef enum logic [1:0] {S_IDLE, S_ISSUE, S_WAIT} seq_state_e;

  seq_state_e state_q;
  logic       sel_upd_q;  // 1: updater owns the port
  logic       done_q;
  blk_size_t  rsp_size_q;
  addr_t      rsp_next_q;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q   <= S_IDLE;
      sel_upd_q <= 1'b0;
      done_q    <= 1'b0;
    end else begin
      done_q <= 1'b0;
      unique case (state_q)
        // client still shows valid while done is high
        S_IDLE: if (!done_q && (walk_mem.cmd_valid || upd_mem.cmd_valid)) begin
          sel_upd_q <= upd_mem.cmd_valid;
          state_q   <= S_ISSUE;
        end
        S_ISSUE: if (mem_req_ready_i) state_q <= S_WAIT;
        S_WAIT: if (mem_rsp_valid_i) begin
          done_q  <= 1'b1;
          state_q <= S_IDLE;
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == S_WAIT && mem_rsp_valid_i) begin
      rsp_size_q <= mem_rsp_size_i;
      rsp_next_q <= mem_rsp_next_i;
    end
  end

  assign mem_req_valid_o = (state_q == S_ISSUE);
  assign mem_req_op_o    = sel_upd_q ? upd_mem.cmd_op   : walk_mem.cmd_op;
  assign mem_req_addr_o  = sel_upd_q ? upd_mem.cmd_addr : walk_mem.cmd_addr;
  assign mem_req_size_o  = sel_upd_q ? upd_mem.cmd_size : walk_mem.cmd_size;
  assign mem_req_next_o  = sel_upd_q ? upd_mem.cmd_next : walk_mem.cmd_next;

  assign walk_mem.cmd_done = done_q && !sel_upd_q;
  assign walk_mem.rsp_size = rsp_size_q;
  assign walk_mem.rsp_next = rsp_next_q;
  assign upd_mem.cmd_done  = done_q && sel_upd_q;
  assign upd_mem.rsp_size  = rsp_size_q;
  assign upd_mem.rsp_next  = rsp_next_q;

  // walk and update phases never overlap
  a_one_client: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(walk_mem.cmd_valid && upd_mem.cmd_valid));

  a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o && $stable(mem_req_op_o)
      && $stable(mem_req_addr_o) && $stable(mem_req_size_o) && $stable(mem_req_next_o));

  a_no_idle_rsp: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q == S_IDLE |-> !mem_rsp_valid_i);

endmodule

// File: hw/list_walker.sv
// free list walker: finds the fit block or the insertion point of a freed block
`include "alloc_defs.svh"

module list_walker
  import heap_pkg::*;
  import mem_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            walk_start_i,
  output logic            walk_done_o,
  input  logic            is_alloc_i,
  input  blk_size_t       size_i,
  input  addr_t           target_i,
  input  alloc_strategy_e strategy_i,
  input  addr_t           head_ptr_i,
  mem_cmd_if.client       mem,
  walk_result_if.producer res
);

  localparam addr_t HDR = addr_t'(`HDR_BYTES);

  typedef enum logic {W_IDLE, W_LOAD} walk_state_e;

  walk_state_e state_q;
  logic        done_q;
  logic        found_q;
  logic        is_head_q;   // current load is the pseudo header
  addr_t       cur_addr_q;
  addr_t       prev_addr_q;
  addr_t       res_prev_q;
  addr_t       res_blk_q;
  addr_t       res_next_q;
  blk_size_t   res_size_q;
  blk_size_t   best_left_q;

  addr_t     free_hdr;
  blk_size_t leftover;
  logic      step;
  logic      fits;
  logic      at_end;
  logic      ins_here;
  logic      take;
  logic      stop;

  assign step     = (state_q == W_LOAD) && mem.cmd_done;
  assign free_hdr = target_i - HDR;
  assign leftover = mem.rsp_size - size_i;
  assign fits     = !is_head_q && (mem.rsp_size >= size_i);  // head carries no payload
  assign at_end   = (mem.rsp_next == '0);
  assign ins_here = at_end || (mem.rsp_next > free_hdr);

  always_comb begin
    take = 1'b0;
    stop = at_end;
    if (!is_alloc_i) begin
      take = ins_here;  // loaded header becomes the predecessor
      stop = ins_here;
    end else if (strategy_i == FIRST_FIT) begin
      take = fits;
      stop = fits || at_end;
    end else begin
      take = fits && (!found_q || leftover < best_left_q);  // tie keeps the earlier block
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= W_IDLE;
      done_q  <= 1'b0;
      found_q <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (state_q == W_IDLE && walk_start_i) begin
        state_q <= W_LOAD;
        found_q <= 1'b0;
      end else if (step) begin
        if (take) found_q <= 1'b1;
        if (stop) begin
          state_q <= W_IDLE;
          done_q  <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == W_IDLE && walk_start_i) begin
      cur_addr_q <= head_ptr_i;
      is_head_q  <= 1'b1;
    end else if (step) begin
      prev_addr_q <= cur_addr_q;
      cur_addr_q  <= mem.rsp_next;
      is_head_q   <= 1'b0;
      if (take) begin
        res_prev_q  <= is_alloc_i ? prev_addr_q : cur_addr_q;
        res_blk_q   <= is_alloc_i ? cur_addr_q : free_hdr;
        res_size_q  <= mem.rsp_size;
        res_next_q  <= mem.rsp_next;
        best_left_q <= leftover;
      end
    end
  end

  assign mem.cmd_valid = (state_q == W_LOAD);
  assign mem.cmd_op    = MEM_LOAD;
  assign mem.cmd_addr  = cur_addr_q;
  assign mem.cmd_size  = '0;
  assign mem.cmd_next  = '0;

  assign walk_done_o   = done_q;
  assign res.found     = found_q;
  assign res.prev_addr = res_prev_q;
  assign res.blk_addr  = res_blk_q;
  assign res.blk_size  = res_size_q;
  assign res.blk_next  = res_next_q;

endmodule

// File: hw/link_updater.sv
// link updater: header writes that split, unlink or insert a block
`include "alloc_defs.svh"

module link_updater
  import heap_pkg::*;
  import mem_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            upd_start_i,
  output logic            upd_done_o,
  input  logic            is_alloc_i,
  input  blk_size_t       size_i,
  input  addr_t           target_i,
  walk_result_if.consumer res,
  mem_cmd_if.client       mem
);

  localparam addr_t HDR = addr_t'(`HDR_BYTES);

  typedef enum logic [2:0] {U_IDLE, U_HDR, U_NEW, U_FREE, U_LINK} upd_state_e;

  upd_state_e state_q;
  logic       done_q;

  blk_size_t leftover;
  logic      split;
  addr_t     new_addr;
  addr_t     free_hdr;
  addr_t     link_next;

  assign leftover = res.blk_size - size_i;
  assign split    = is_alloc_i && (leftover >= blk_size_t'(`MIN_SPLIT));
  assign new_addr = res.blk_addr + HDR + size_i;  // remainder header
  assign free_hdr = target_i - HDR;

  always_comb begin
    if (!is_alloc_i) link_next = free_hdr;
    else if (split) link_next = new_addr;
    else link_next = res.blk_next;  // unlink whole block
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= U_IDLE;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      unique case (state_q)
        U_IDLE: if (upd_start_i) begin
          if (!is_alloc_i) state_q <= U_FREE;
          else if (!res.found) done_q <= 1'b1;  // nothing fits, list untouched
          else if (split) state_q <= U_HDR;
          else state_q <= U_LINK;
        end
        U_HDR:  if (mem.cmd_done) state_q <= U_NEW;
        U_NEW:  if (mem.cmd_done) state_q <= U_LINK;
        U_FREE: if (mem.cmd_done) state_q <= U_LINK;
        U_LINK: if (mem.cmd_done) begin
          state_q <= U_IDLE;
          done_q  <= 1'b1;
        end
        default: state_q <= U_IDLE;
      endcase
    end
  end

  // relink of the predecessor is the default command
  always_comb begin
    mem.cmd_valid = (state_q != U_IDLE);
    mem.cmd_op    = MEM_WRITE_NEXT;
    mem.cmd_addr  = res.prev_addr;
    mem.cmd_size  = '0;
    mem.cmd_next  = link_next;
    case (state_q)
      U_HDR: begin
        mem.cmd_op   = MEM_WRITE_HEADER;
        mem.cmd_addr = res.blk_addr;
        mem.cmd_size = size_i;
        mem.cmd_next = '0;
      end
      U_NEW: begin
        mem.cmd_op   = MEM_WRITE_HEADER;
        mem.cmd_addr = new_addr;
        mem.cmd_size = leftover - HDR;
        mem.cmd_next = res.blk_next;
      end
      U_FREE: begin
        mem.cmd_addr = free_hdr;
        mem.cmd_next = res.blk_next;  // predecessor's old next
      end
      default: ;
    endcase
  end

  assign upd_done_o = done_q;

endmodule

// File: hw/heap_alloc_ctrl.sv
// request controller: latches a request, runs walk then update, returns the result
`include "alloc_defs.svh"

module heap_alloc_ctrl
  import heap_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_ni,
  input  alloc_strategy_e strategy_i,
  input  logic            req_valid_i,
  output logic            req_ready_o,
  input  logic            req_is_alloc_i,
  input  blk_size_t       req_size_i,
  input  addr_t           req_addr_i,
  output logic            rsp_valid_o,
  input  logic            rsp_ready_i,
  output logic            rsp_is_alloc_o,
  output addr_t           rsp_addr_o,
  output logic            walk_start_o,
  input  logic            walk_done_i,
  output logic            upd_start_o,
  input  logic            upd_done_i,
  walk_result_if.consumer walk_res,
  output logic            req_is_alloc_q_o,
  output blk_size_t       req_size_q_o,
  output addr_t           req_addr_q_o,
  output alloc_strategy_e strategy_q_o
);

  typedef enum logic [1:0] {C_IDLE, C_WALK, C_UPDATE, C_RESP} ctrl_state_e;

  ctrl_state_e     state_q;
  logic            walk_start_q;
  logic            upd_start_q;
  logic            is_alloc_q;
  blk_size_t       size_q;
  addr_t           addr_q;
  alloc_strategy_e strategy_q;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q      <= C_IDLE;
      walk_start_q <= 1'b0;
      upd_start_q  <= 1'b0;
    end else begin
      walk_start_q <= 1'b0;
      upd_start_q  <= 1'b0;
      unique case (state_q)
        C_IDLE: if (req_valid_i) begin
          state_q      <= C_WALK;
          walk_start_q <= 1'b1;
        end
        C_WALK: if (walk_done_i) begin
          state_q     <= C_UPDATE;
          upd_start_q <= 1'b1;  // also for a failed alloc
        end
        C_UPDATE: if (upd_done_i) state_q <= C_RESP;
        C_RESP:   if (rsp_ready_i) state_q <= C_IDLE;
        default:  state_q <= C_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == C_IDLE && req_valid_i) begin
      is_alloc_q <= req_is_alloc_i;
      size_q     <= req_size_i;
      addr_q     <= req_addr_i;
      strategy_q <= strategy_i;
    end
  end

  assign req_ready_o    = (state_q == C_IDLE);
  assign rsp_valid_o    = (state_q == C_RESP);
  assign rsp_is_alloc_o = is_alloc_q;

  // payload pointer just past the header, zero when nothing fits
  always_comb begin
    if (!is_alloc_q) rsp_addr_o = addr_q;
    else if (walk_res.found) rsp_addr_o = walk_res.blk_addr + addr_t'(`HDR_BYTES);
    else rsp_addr_o = '0;
  end

  assign walk_start_o     = walk_start_q;
  assign upd_start_o      = upd_start_q;
  assign req_is_alloc_q_o = is_alloc_q;
  assign req_size_q_o     = size_q;
  assign req_addr_q_o     = addr_q;
  assign strategy_q_o     = strategy_q;

  // result comes from the walker and must hold under back-pressure
  a_rsp_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_addr_o)
      && $stable(rsp_is_alloc_o));

endmodule

// File: hw/heap_alloc_top.sv
// heap allocator top: request port, free list phases and header memory port
module heap_alloc_top (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  heap_pkg::alloc_strategy_e strategy_i,
  input  heap_pkg::addr_t           head_ptr_i,
  input  logic                      req_valid_i,
  output logic                      req_ready_o,
  input  logic                      req_is_alloc_i,
  input  heap_pkg::blk_size_t       req_size_i,
  input  heap_pkg::addr_t           req_addr_i,
  output logic                      rsp_valid_o,
  input  logic                      rsp_ready_i,
  output logic                      rsp_is_alloc_o,
  output heap_pkg::addr_t           rsp_addr_o,
  output logic                      mem_req_valid_o,
  input  logic                      mem_req_ready_i,
  output logic [1:0]                mem_req_op_o,
  output heap_pkg::addr_t           mem_req_addr_o,
  output heap_pkg::blk_size_t       mem_req_size_o,
  output heap_pkg::addr_t           mem_req_next_o,
  input  logic                      mem_rsp_valid_i,
  input  heap_pkg::blk_size_t       mem_rsp_size_i,
  input  heap_pkg::addr_t           mem_rsp_next_i
);

  logic                      walk_start;
  logic                      walk_done;
  logic                      upd_start;
  logic                      upd_done;
  logic                      req_is_alloc_q;
  heap_pkg::blk_size_t       req_size_q;
  heap_pkg::addr_t           req_addr_q;
  heap_pkg::alloc_strategy_e strategy_q;

  mem_cmd_if     walk_mem ();
  mem_cmd_if     upd_mem ();
  walk_result_if walk_res ();

  heap_alloc_ctrl heap_alloc_ctrl_inst (
    .clk_i, .rst_ni, .strategy_i,
    .req_valid_i, .req_ready_o, .req_is_alloc_i, .req_size_i, .req_addr_i,
    .rsp_valid_o, .rsp_ready_i, .rsp_is_alloc_o, .rsp_addr_o,
    .walk_start_o(walk_start), .walk_done_i(walk_done),
    .upd_start_o(upd_start), .upd_done_i(upd_done),
    .walk_res(walk_res.consumer),
    .req_is_alloc_q_o(req_is_alloc_q), .req_size_q_o(req_size_q),
    .req_addr_q_o(req_addr_q), .strategy_q_o(strategy_q)
  );

  list_walker list_walker_inst (
    .clk_i, .rst_ni,
    .walk_start_i(walk_start), .walk_done_o(walk_done),
    .is_alloc_i(req_is_alloc_q), .size_i(req_size_q), .target_i(req_addr_q),
    .strategy_i(strategy_q), .head_ptr_i,
    .mem(walk_mem.client), .res(walk_res.producer)
  );

  link_updater link_updater_inst (
    .clk_i, .rst_ni,
    .upd_start_i(upd_start), .upd_done_o(upd_done),
    .is_alloc_i(req_is_alloc_q), .size_i(req_size_q), .target_i(req_addr_q),
    .res(walk_res.consumer), .mem(upd_mem.client)
  );

  mem_sequencer mem_sequencer_inst (
    .clk_i, .rst_ni,
    .walk_mem(walk_mem.server), .upd_mem(upd_mem.server),
    .mem_req_valid_o, .mem_req_ready_i, .mem_req_op_o,
    .mem_req_addr_o, .mem_req_size_o, .mem_req_next_o,
    .mem_rsp_valid_i, .mem_rsp_size_i, .mem_rsp_next_i
  );

endmodule

// File: test/heap_mem_model.sv
// header memory model: stores block headers and answers requests after random stalls
module heap_mem_model
  import mem_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        req_valid_i,
  input  logic        req_ready_i,  // same level the DUT sees
  input  logic [1:0]  req_op_i,
  input  logic [31:0] req_addr_i,
  input  logic [31:0] req_size_i,
  input  logic [31:0] req_next_i,
  input  logic        rsp_go_i,     // releases the pending response
  output logic        rsp_valid_o,
  output logic [31:0] rsp_size_o,
  output logic [31:0] rsp_next_o
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [31:0] size_mem [0:8191];
  logic [31:0] next_mem [0:8191];
  int          write_count = 0;
  int          bad_count = 0;

  logic        busy_q;
  mem_op_e     op_q;
  logic [31:0] addr_q;
  logic [31:0] size_q;
  logic [31:0] next_q;

  function automatic logic [12:0] word_index(input logic [31:0] addr);
    return addr[15:3];
  endfunction

  initial begin
    for (int i = 0; i < 8192; i++) begin
      size_mem[i] = 32'hbad0_0000 ^ (i << 3);  // junk shows up on a stray load
      next_mem[i] = 32'hf0f0_0000 ^ (i << 3);
    end
    size_mem[word_index(32'h100)] = 32'd0;  // head pseudo header
    next_mem[word_index(32'h100)] = 32'h1000;
    size_mem[word_index(32'h1000)] = 32'd64;
    next_mem[word_index(32'h1000)] = 32'h2000;
    size_mem[word_index(32'h2000)] = 32'd24;
    next_mem[word_index(32'h2000)] = 32'h3000;
    size_mem[word_index(32'h3000)] = 32'd200;
    next_mem[word_index(32'h3000)] = 32'h0;
  end

  always @(posedge clk_i) begin
    if (!rst_ni) begin
      busy_q      <= 1'b0;
      rsp_valid_o <= 1'b0;
    end else begin
      rsp_valid_o <= 1'b0;
      if (!busy_q) begin
        if (req_valid_i && req_ready_i) begin
          busy_q <= 1'b1;
          op_q   <= mem_op_e'(req_op_i);
          addr_q <= req_addr_i;
          size_q <= req_size_i;
          next_q <= req_next_i;
          if (req_addr_i[31:16] != 16'h0 || req_addr_i[2:0] != 3'h0) begin
            bad_count++;
            $display("memory model: request to bad address %h at %0t", req_addr_i, $time);
          end
        end
      end else if (rsp_go_i) begin
        busy_q      <= 1'b0;
        rsp_valid_o <= 1'b1;
        case (op_q)
          MEM_LOAD: begin
            rsp_size_o <= size_mem[word_index(addr_q)];
            rsp_next_o <= next_mem[word_index(addr_q)];
          end
          MEM_WRITE_HEADER: begin
            size_mem[word_index(addr_q)] = size_q;
            next_mem[word_index(addr_q)] = next_q;
            write_count++;
          end
          MEM_WRITE_NEXT: begin
            next_mem[word_index(addr_q)] = next_q;
            write_count++;
          end
          default: begin
            bad_count++;
            $display("memory model: unknown operation at %0t", $time);
          end
        endcase
      end
    end
  end

endmodule

// File: test/heap_alloc_tb.sv
// heap allocator testbench: table of requests under random memory and response stalls
module heap_alloc_tb
  import heap_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NROWS      = 9;
  localparam int MAX_CYCLES = NROWS * 400;

  logic            clk;
  logic            rst_n;
  alloc_strategy_e strategy;
  addr_t           head_ptr;
  logic            req_valid;
  logic            req_ready;
  logic            req_is_alloc;
  blk_size_t       req_size;
  addr_t           req_addr;
  logic            rsp_valid;
  logic            rsp_ready = 1'b0;
  logic            rsp_is_alloc;
  addr_t           rsp_addr;
  logic            mem_req_valid;
  logic            mem_req_ready = 1'b0;
  logic [1:0]      mem_req_op;
  addr_t           mem_req_addr;
  blk_size_t       mem_req_size;
  addr_t           mem_req_next;
  logic            mem_rsp_valid;
  blk_size_t       mem_rsp_size;
  addr_t           mem_rsp_next;
  logic            rsp_go = 1'b0;

  logic [31:0] lfsr_state = 32'h1556;
  int          errors = 0;
  int          checks = 0;
  int          rsp_count = 0;
  int          cycle_count = 0;
  int          n_rows = 0;
  addr_t       got_addr;
  logic        got_is_alloc;

  // stimulus table, one entry per request
  logic            row_alloc [NROWS];
  alloc_strategy_e row_strat [NROWS];
  logic [31:0]     row_arg [NROWS];
  addr_t           row_exp [NROWS];
  int              row_len [NROWS];
  addr_t           exp_blk_addr [NROWS][4];
  blk_size_t       exp_blk_size [NROWS][4];

  heap_alloc_top heap_alloc_top_inst (
    .clk_i(clk), .rst_ni(rst_n), .strategy_i(strategy), .head_ptr_i(head_ptr),
    .req_valid_i(req_valid), .req_ready_o(req_ready), .req_is_alloc_i(req_is_alloc),
    .req_size_i(req_size), .req_addr_i(req_addr),
    .rsp_valid_o(rsp_valid), .rsp_ready_i(rsp_ready), .rsp_is_alloc_o(rsp_is_alloc),
    .rsp_addr_o(rsp_addr),
    .mem_req_valid_o(mem_req_valid), .mem_req_ready_i(mem_req_ready),
    .mem_req_op_o(mem_req_op), .mem_req_addr_o(mem_req_addr),
    .mem_req_size_o(mem_req_size), .mem_req_next_o(mem_req_next),
    .mem_rsp_valid_i(mem_rsp_valid), .mem_rsp_size_i(mem_rsp_size),
    .mem_rsp_next_i(mem_rsp_next)
  );

  heap_mem_model heap_mem_model_inst (
    .clk_i(clk), .rst_ni(rst_n),
    .req_valid_i(mem_req_valid), .req_ready_i(mem_req_ready), .req_op_i(mem_req_op),
    .req_addr_i(mem_req_addr), .req_size_i(mem_req_size), .req_next_i(mem_req_next),
    .rsp_go_i(rsp_go), .rsp_valid_o(mem_rsp_valid), .rsp_size_o(mem_rsp_size),
    .rsp_next_o(mem_rsp_next)
  );

  always #10 clk = ~clk;

  function automatic logic next_rand_bit();
    logic b;
    b = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (b) lfsr_state = lfsr_state ^ 32'h8020_0003;
    return b;
  endfunction

  // stalls on the memory port and the response port
  always @(posedge clk) begin
    #2;
    mem_req_ready = next_rand_bit() | next_rand_bit();
    rsp_go = next_rand_bit();
    rsp_ready = next_rand_bit() | next_rand_bit();
  end

  // accepted responses sampled mid-cycle
  always @(negedge clk) begin
    if (rst_n && rsp_valid && rsp_ready) begin
      rsp_count++;
      got_addr = rsp_addr;
      got_is_alloc = rsp_is_alloc;
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > MAX_CYCLES) begin
      $display("timeout: run still busy after %0d cycles", MAX_CYCLES);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic flag_error(input string msg);
    $display("** Error @ %0t: %s", $time, msg);
    errors++;
  endtask

  task automatic add_row(input logic is_alloc, input alloc_strategy_e strat,
                         input logic [31:0] arg, input addr_t rsp,
                         input logic [0:3][31:0] addrs, input logic [0:3][31:0] sizes);
    row_alloc[n_rows] = is_alloc;
    row_strat[n_rows] = strat;
    row_arg[n_rows] = arg;
    row_exp[n_rows] = rsp;
    exp_blk_addr[n_rows][0] = addrs[0];
    exp_blk_addr[n_rows][1] = addrs[1];
    exp_blk_addr[n_rows][2] = addrs[2];
    exp_blk_addr[n_rows][3] = addrs[3];
    exp_blk_size[n_rows][0] = sizes[0];
    exp_blk_size[n_rows][1] = sizes[1];
    exp_blk_size[n_rows][2] = sizes[2];
    exp_blk_size[n_rows][3] = sizes[3];
    row_len[n_rows] = 0;
    for (int k = 0; k < 4; k++) begin
      if (exp_blk_addr[n_rows][k] != '0) row_len[n_rows] = k + 1;  // zero ends the list
    end
    n_rows++;
  endtask

  // walks the list as it sits in the model
  task automatic check_list(input int idx);
    addr_t addr;
    int    k;
    k = 0;
    addr = heap_mem_model_inst.next_mem[head_ptr[15:3]];
    while (addr != '0 && k < 8) begin
      checks++;
      if (k >= row_len[idx]) begin
        flag_error($sformatf("row %0d: extra free block %h", idx, addr));
      end else if (addr != exp_blk_addr[idx][k]) begin
        flag_error($sformatf("row %0d: block %0d at %h, expected %h", idx, k, addr,
                             exp_blk_addr[idx][k]));
      end else if (heap_mem_model_inst.size_mem[addr[15:3]] != exp_blk_size[idx][k]) begin
        flag_error($sformatf("row %0d: block %h size %0d, expected %0d", idx, addr,
                             heap_mem_model_inst.size_mem[addr[15:3]], exp_blk_size[idx][k]));
      end
      addr = heap_mem_model_inst.next_mem[addr[15:3]];
      k++;
    end
    checks++;
    if (k != row_len[idx]) begin
      flag_error($sformatf("row %0d: list has %0d blocks, expected %0d", idx, k, row_len[idx]));
    end
  endtask

  task automatic run_row(input int idx);
    int start_writes;
    start_writes = heap_mem_model_inst.write_count;
    checks++;
    if (rsp_count != idx) flag_error($sformatf("row %0d: %0d responses so far", idx, rsp_count));
    while (!req_ready) next_cycle();
    req_valid = 1'b1;
    req_is_alloc = row_alloc[idx];
    strategy = row_strat[idx];
    req_size = row_alloc[idx] ? row_arg[idx] : '0;
    req_addr = row_alloc[idx] ? '0 : row_arg[idx];
    next_cycle();
    req_valid = 1'b0;
    while (rsp_count == idx) next_cycle();
    checks++;
    if (got_addr != row_exp[idx]) begin
      flag_error($sformatf("row %0d: rsp_addr %h, expected %h", idx, got_addr, row_exp[idx]));
    end
    checks++;
    if (got_is_alloc != row_alloc[idx]) flag_error($sformatf("row %0d: wrong rsp_is_alloc", idx));
    checks++;
    if (row_alloc[idx] && row_exp[idx] == '0
        && heap_mem_model_inst.write_count != start_writes) begin
      flag_error($sformatf("row %0d: failed allocation wrote memory", idx));
    end
    check_list(idx);
  endtask

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    strategy = FIRST_FIT;
    head_ptr = 32'h100;
    req_valid = 1'b0;
    req_is_alloc = 1'b0;
    req_size = '0;
    req_addr = '0;
    // alloc, strategy, size or address, rsp_addr, free list addresses and sizes
    add_row(1'b1, FIRST_FIT, 32'd40, 32'h1008,
            {32'h1030, 32'h2000, 32'h3000, 32'h0}, {32'd16, 32'd24, 32'd200, 32'd0});
    add_row(1'b1, BEST_FIT, 32'd20, 32'h2008,
            {32'h1030, 32'h3000, 32'h0, 32'h0}, {32'd16, 32'd200, 32'd0, 32'd0});
    add_row(1'b1, FIRST_FIT, 32'd500, 32'h0,
            {32'h1030, 32'h3000, 32'h0, 32'h0}, {32'd16, 32'd200, 32'd0, 32'd0});
    add_row(1'b1, BEST_FIT, 32'd500, 32'h0,
            {32'h1030, 32'h3000, 32'h0, 32'h0}, {32'd16, 32'd200, 32'd0, 32'd0});
    add_row(1'b0, FIRST_FIT, 32'h2008, 32'h2008,
            {32'h1030, 32'h2000, 32'h3000, 32'h0}, {32'd16, 32'd24, 32'd200, 32'd0});
    add_row(1'b0, FIRST_FIT, 32'h1008, 32'h1008,  // lands before the first entry
            {32'h1000, 32'h1030, 32'h2000, 32'h3000}, {32'd40, 32'd16, 32'd24, 32'd200});
    add_row(1'b1, BEST_FIT, 32'd200, 32'h3008,
            {32'h1000, 32'h1030, 32'h2000, 32'h0}, {32'd40, 32'd16, 32'd24, 32'd0});
    add_row(1'b1, BEST_FIT, 32'd16, 32'h1038,
            {32'h1000, 32'h2000, 32'h0, 32'h0}, {32'd40, 32'd24, 32'd0, 32'd0});
    add_row(1'b1, FIRST_FIT, 32'd16, 32'h1008,  // takes 0x1000 over the closer 0x2000
            {32'h1018, 32'h2000, 32'h0, 32'h0}, {32'd16, 32'd24, 32'd0, 32'd0});
    repeat (3) @(posedge clk);
    #2;
    rst_n = 1'b1;
    for (int i = 0; i < NROWS; i++) run_row(i);
    repeat (5) next_cycle();
    checks++;
    if (rsp_count != NROWS) begin
      flag_error($sformatf("%0d responses for %0d requests", rsp_count, NROWS));
    end
    errors += heap_mem_model_inst.bad_count;
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: sources.f
+incdir+hw
hw/heap_pkg.sv
hw/mem_pkg.sv
hw/mem_cmd_if.sv
hw/mem_sequencer.sv
hw/list_walker.sv
hw/link_updater.sv
hw/heap_alloc_ctrl.sv
hw/heap_alloc_top.sv
test/heap_mem_model.sv
test/heap_alloc_tb.sv

// File: Makefile
SRCS := $(filter-out +%,$(shell cat sources.f)) hw/alloc_defs.svh

obj_dir/Vheap_alloc_tb: sources.f $(SRCS)
	verilator --binary --assert --timescale 1ns/1ps -f sources.f --top-module heap_alloc_tb -j 0

run: obj_dir/Vheap_alloc_tb
	./obj_dir/Vheap_alloc_tb | tee sim.log
	! grep -q "SOME TESTS FAILED" sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
